//--- rtl/linkPkg.sv
package linkPkg;

    // receiver side of the request link
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0, // waiting for inReq
        RX_HOLD  = 2'd1, // request latched, offered to shifter
        RX_ACKED = 2'd2  // inAck high until inReq drops
    } rxState;

    // sender side of the result link
    typedef enum logic [1:0] {
        TX_IDLE    = 2'd0, // ready for next result
        TX_REQ     = 2'd1, // outReq high, waiting for outAck
        TX_RELEASE = 2'd2  // waiting for outAck to drop
    } txState;

endpackage

//--- rtl/shiftBarrel.sv
`timescale 1ns/1ps

`include "shiftSettings_settings.svh"

module shiftBarrel (
    input  logic              clk,
    input  logic              rst,

    input  logic              reqValid,
    output logic              reqReady,
    input  shiftPkg::shiftData reqData,
    input  shiftPkg::shiftAmt  reqAmt,
    input  shiftPkg::shiftOp   reqOp,

    output logic              resValid,
    input  logic              resReady,
    output shiftPkg::shiftData resData
);

    localparam int Msb = `SHIFT_WIDTH - 1;

    // one shift rule for both stages, so the two steps add up
    function automatic shiftPkg::shiftData shiftStep(
        input shiftPkg::shiftData d,
        input shiftPkg::shiftAmt  n,
        input shiftPkg::shiftOp   op,
        input logic               fill
    );
        logic [2*`SHIFT_WIDTH-1:0] wide;
        shiftPkg::shiftData        res;
        wide = '0;
        res  = d;
        case (op)
            shiftPkg::SHIFT_SLL: res = d << n;
            shiftPkg::SHIFT_SRL: res = d >> n;
            shiftPkg::SHIFT_SRA: begin
                wide = {{`SHIFT_WIDTH{fill}}, d} >> n; // fill from original top bit
                res  = wide[Msb:0];
            end
            shiftPkg::SHIFT_SLA: res = {d[Msb], d[Msb-1:0] << n};
            shiftPkg::SHIFT_ROL: begin
                wide = {d, d} << n;
                res  = wide[2*`SHIFT_WIDTH-1:`SHIFT_WIDTH];
            end
            shiftPkg::SHIFT_ROR: begin
                wide = {d, d} >> n;
                res  = wide[Msb:0];
            end
            default: res = d;
        endcase
        return res;
    endfunction

    // stage 1 registers
    logic                             s1Valid;
    shiftPkg::shiftData               s1Data;
    logic [`SHIFT_COARSE_LSB-1:0]     s1Lo;   // amount bits left for stage 2
    shiftPkg::shiftOp                 s1Op;
    logic                             s1Sign; // operand top bit before any shift

    // stage 2 registers
    logic               s2Valid;
    shiftPkg::shiftData s2Data;

    logic s1Free;
    logic s2Free;

    shiftPkg::shiftAmt coarseAmt; // multiple of four
    shiftPkg::shiftAmt fineAmt;   // 0 to 3

    assign coarseAmt = {reqAmt[`SHIFT_AMT_BITS-1:`SHIFT_COARSE_LSB], {`SHIFT_COARSE_LSB{1'b0}}};
    assign fineAmt   = {{(`SHIFT_AMT_BITS-`SHIFT_COARSE_LSB){1'b0}}, s1Lo};

    // a stage moves when the next one is empty or moving
    assign s2Free   = !s2Valid || resReady;
    assign s1Free   = !s1Valid || s2Free;
    assign reqReady = s1Free;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            if (s1Free) s1Valid <= reqValid;
            if (s2Free) s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1Free && reqValid) begin
            s1Data <= shiftStep(reqData, coarseAmt, reqOp, reqData[Msb]);
            s1Lo   <= reqAmt[`SHIFT_COARSE_LSB-1:0];
            s1Op   <= reqOp;
            s1Sign <= reqData[Msb];
        end
        if (s2Free && s1Valid) begin
            s2Data <= shiftStep(s1Data, fineAmt, s1Op, s1Sign);
        end
    end

    assign resValid = s2Valid;
    assign resData  = s2Data;

endmodule

//--- rtl/shiftPkg.sv
`include "shiftSettings_settings.svh"

package shiftPkg;

    // operand and result word
    typedef logic [`SHIFT_WIDTH-1:0] shiftData;

    typedef logic [`SHIFT_AMT_BITS-1:0] shiftAmt; // wraps, no overflow case

    // shift opcodes as carried on the request link
    typedef enum logic [2:0] {
        SHIFT_SLL = 3'd0, // logical left, zero fill
        SHIFT_SRL = 3'd1, // logical right, zero fill
        SHIFT_SRA = 3'd2, // arithmetic right, sign fill
        SHIFT_SLA = 3'd3, // top bit kept, lower bits shift left
        SHIFT_ROL = 3'd4,
        SHIFT_ROR = 3'd5
    } shiftOp;

    // codes 6 and 7 unused, the shifter passes data unchanged for them

endpackage

//--- rtl/shiftRequestPort.sv
`timescale 1ns/1ps

module shiftRequestPort (
    input  logic              clk,
    input  logic              rst,

    // four-phase link from the producer
    input  logic              inReq,
    output logic              inAck,
    input  shiftPkg::shiftData inData,
    input  shiftPkg::shiftAmt  inAmt,
    input  shiftPkg::shiftOp   inOp,

    // valid/ready link to the shifter
    output logic              reqValid,
    input  logic              reqReady,
    output shiftPkg::shiftData reqData,
    output shiftPkg::shiftAmt  reqAmt,
    output shiftPkg::shiftOp   reqOp
);

    linkPkg::rxState state;

    logic takeReq; // new request seen in idle
    logic handOff; // shifter takes the latched request

    assign takeReq = (state == linkPkg::RX_IDLE) && inReq;
    assign handOff = reqValid && reqReady;

    // offered to the shifter only while holding
    assign reqValid = (state == linkPkg::RX_HOLD);

    // ack follows acceptance, so a stalled pipeline holds the producer
    assign inAck = (state == linkPkg::RX_ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= linkPkg::RX_IDLE;
        end else begin
            case (state)
                linkPkg::RX_IDLE: begin
                    if (inReq) begin
                        state <= linkPkg::RX_HOLD;
                    end
                end
                linkPkg::RX_HOLD: begin
                    if (handOff) begin
                        state <= linkPkg::RX_ACKED;
                    end
                end
                linkPkg::RX_ACKED: begin
                    if (!inReq) begin // producer released, close the cycle
                        state <= linkPkg::RX_IDLE;
                    end
                end
                default: state <= linkPkg::RX_IDLE;
            endcase
        end
    end

    // fields are stable while inReq is high, one capture is enough
    always_ff @(posedge clk) begin
        if (takeReq) begin
            reqData <= inData;
            reqAmt  <= inAmt;
            reqOp   <= inOp;
        end
    end

endmodule

//--- rtl/shiftResultPort.sv
`timescale 1ns/1ps

module shiftResultPort (
    input  logic              clk,
    input  logic              rst,

    // valid/ready link from the shifter
    input  logic              resValid,
    output logic              resReady,
    input  shiftPkg::shiftData resData,

    // four-phase link to the consumer
    output logic              outReq,
    input  logic              outAck,
    output shiftPkg::shiftData outData
);

    linkPkg::txState state;

    logic takeRes;

    // only one result held at a time
    assign resReady = (state == linkPkg::TX_IDLE);
    assign takeRes  = resValid && resReady;

    assign outReq = (state == linkPkg::TX_REQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= linkPkg::TX_IDLE;
        end else begin
            case (state)
                linkPkg::TX_IDLE: begin
                    if (takeRes) begin
                        state <= linkPkg::TX_REQ;
                    end
                end
                linkPkg::TX_REQ: begin
                    if (outAck) begin // consumer has the data
                        state <= linkPkg::TX_RELEASE;
                    end
                end
                linkPkg::TX_RELEASE: begin
                    if (!outAck) begin
                        state <= linkPkg::TX_IDLE;
                    end
                end
                default: state <= linkPkg::TX_IDLE;
            endcase
        end
    end

    // held until the next result, so stable across the whole cycle
    always_ff @(posedge clk) begin
        if (takeRes) begin
            outData <= resData;
        end
    end

endmodule

//--- rtl/shiftSettings_settings.svh
`ifndef SHIFT_SETTINGS_SVH
`define SHIFT_SETTINGS_SVH

// operand and result width
`define SHIFT_WIDTH 32

// 5-bit shift amount wraps at 32
`define SHIFT_AMT_BITS 5

`define SHIFT_COARSE_LSB 2 // lowest amount bit handled by stage 1

`endif

//--- rtl/shiftUnit.sv
`timescale 1ns/1ps

module shiftUnit (
    input  logic              clk,
    input  logic              rst,

    // request link from the producer
    input  logic              inReq,
    output logic              inAck,
    input  shiftPkg::shiftData inData,
    input  shiftPkg::shiftAmt  inAmt,
    input  shiftPkg::shiftOp   inOp,

    // result link to the consumer
    output logic              outReq,
    input  logic              outAck,
    output shiftPkg::shiftData outData
);

    logic              reqValid;
    logic              reqReady;
    shiftPkg::shiftData reqData;
    shiftPkg::shiftAmt  reqAmt;
    shiftPkg::shiftOp   reqOp;

    logic              resValid;
    logic              resReady;
    shiftPkg::shiftData resData;

    shiftRequestPort reqPort_i (
        .clk      (clk),
        .rst      (rst),
        .inReq    (inReq),
        .inAck    (inAck),
        .inData   (inData),
        .inAmt    (inAmt),
        .inOp     (inOp),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqData  (reqData),
        .reqAmt   (reqAmt),
        .reqOp    (reqOp)
    );

    shiftBarrel barrel_i (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqData  (reqData),
        .reqAmt   (reqAmt),
        .reqOp    (reqOp),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData)
    );

    shiftResultPort resPort_i (
        .clk      (clk),
        .rst      (rst),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData),
        .outReq   (outReq),
        .outAck   (outAck),
        .outData  (outData)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the shift unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module shiftUnitTb -f shiftUnit.f -o shiftUnitSim \
    && ./obj_dir/shiftUnitSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log

# the log decides pass or fail
grep -qx "NO ERRORS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- shiftUnit.f
+incdir+rtl
rtl/shiftPkg.sv
rtl/linkPkg.sv
rtl/shiftRequestPort.sv
rtl/shiftBarrel.sv
rtl/shiftResultPort.sv
rtl/shiftUnit.sv
verification/shiftTbClock.sv
verification/shiftUnitTb.sv

//--- verification/shiftTbClock.sv
`timescale 1ns/1ps

module shiftTbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0; // released at the same offset as other inputs
    end

endmodule

//--- verification/shiftUnitTb.sv
`timescale 1ns/1ps

`include "shiftSettings_settings.svh"

module shiftUnitTb;

    localparam int RequestCount     = 106; // 60 + 2 + 4 + 40 over all tests
    localparam int CyclesPerRequest = 200;

    logic               clk;
    logic               rst;
    logic               inReq;
    logic               inAck;
    shiftPkg::shiftData inData;
    shiftPkg::shiftAmt  inAmt;
    shiftPkg::shiftOp   inOp;
    logic               outReq;
    logic               outAck;
    shiftPkg::shiftData outData;

    int     errorCount;
    int     checkCount;
    int     acceptedCount; // requests acknowledged so far
    integer seed;

    shiftPkg::shiftData expQ[$]; // expected results in issue order

    shiftTbClock clkGen_i (
        .clk (clk),
        .rst (rst)
    );

    shiftUnit dut_i (
        .clk     (clk),
        .rst     (rst),
        .inReq   (inReq),
        .inAck   (inAck),
        .inData  (inData),
        .inAmt   (inAmt),
        .inOp    (inOp),
        .outReq  (outReq),
        .outAck  (outAck),
        .outData (outData)
    );

    // expected result straight from the opcode definitions
    function automatic shiftPkg::shiftData refShift(
        input shiftPkg::shiftData d,
        input shiftPkg::shiftAmt  amt,
        input shiftPkg::shiftOp   op
    );
        shiftPkg::shiftData msbMask;
        shiftPkg::shiftData r;
        int                 back;
        msbMask = {1'b1, {(`SHIFT_WIDTH-1){1'b0}}};
        back    = `SHIFT_WIDTH - int'(amt); // shift of 32 gives zero
        case (op)
            shiftPkg::SHIFT_SLL: r = d << amt;
            shiftPkg::SHIFT_SRL: r = d >> amt;
            shiftPkg::SHIFT_SRA: r = $signed(d) >>> amt;
            shiftPkg::SHIFT_SLA: r = (d & msbMask) | ((d << amt) & ~msbMask);
            shiftPkg::SHIFT_ROL: r = (d << amt) | (d >> back);
            shiftPkg::SHIFT_ROR: r = (d >> amt) | (d << back);
            default:             r = d;
        endcase
        return r;
    endfunction

    // waits for the next edge plus the drive offset
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic checkData(
        input string              name,
        input shiftPkg::shiftData exp,
        input shiftPkg::shiftData act
    );
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic reportError(input string msg);
        errorCount++;
        $display("ERROR: %s", msg);
    endtask

    // producer side of the four-phase request link
    task automatic sendRequest(
        input shiftPkg::shiftData data,
        input shiftPkg::shiftAmt  amt,
        input shiftPkg::shiftOp   op
    );
        expQ.push_back(refShift(data, amt, op));
        inData = data;
        inAmt  = amt;
        inOp   = op;
        inReq  = 1'b1;
        do begin
            tick();
        end while (!inAck);
        acceptedCount++;
        inReq = 1'b0;
        do begin
            tick();
        end while (inAck);
    endtask

    // consumer side of the four-phase result link
    // delay counts the cycles before outAck rises
    task automatic receiveResult(input string name, input int delay);
        shiftPkg::shiftData got;
        shiftPkg::shiftData exp;
        do begin
            tick();
        end while (!outReq);
        got = outData;
        repeat (delay) tick();
        outAck = 1'b1;
        do begin
            tick();
        end while (outReq);
        outAck = 1'b0;
        if (expQ.size() == 0) begin
            reportError($sformatf("%s: result arrived with no request outstanding", name));
        end else begin
            exp = expQ.pop_front();
            checkData(name, exp, got);
        end
    endtask

    task automatic testReset();
        checkBit("reset inAck", 1'b0, inAck);
        checkBit("reset outReq", 1'b0, outReq);
    endtask

    task automatic testEachOp();
        shiftPkg::shiftAmt  amtList[5];
        shiftPkg::shiftData dataList[2];
        shiftPkg::shiftOp   op;
        string              name;
        amtList  = '{5'd0, 5'd1, 5'd4, 5'd5, 5'd31};
        dataList = '{32'hf0a5_3c91, 32'h4b1e_96c3}; // top bit set, then clear
        for (int k = 0; k < 6; k++) begin
            op = shiftPkg::shiftOp'(k);
            for (int a = 0; a < 5; a++) begin
                for (int d = 0; d < 2; d++) begin
                    name = $sformatf("eachOp %s amt %0d data %h",
                                     op.name(), amtList[a], dataList[d]);
                    fork
                        sendRequest(dataList[d], amtList[a], op);
                        receiveResult(name, 0);
                    join
                end
            end
        end
    endtask

    task automatic testHandshake();
        shiftPkg::shiftData data;
        shiftPkg::shiftData seen;
        int                 waitCycles;
        data = 32'hc0de_1235;
        checkBit("handshake inAck before inReq", 1'b0, inAck);
        inData = data;
        inAmt  = 5'd9;
        inOp   = shiftPkg::SHIFT_SRA;
        fork
            begin
                inReq      = 1'b1;
                waitCycles = 0;
                do begin
                    tick();
                    waitCycles++;
                end while (!inAck);
                if (waitCycles < 2) begin
                    reportError($sformatf("inAck rose %0d cycles after inReq, too early",
                                          waitCycles));
                end
                repeat (3) begin // ack must hold while inReq is still up
                    tick();
                    checkBit("handshake inAck held", 1'b1, inAck);
                end
                inReq = 1'b0;
                do begin
                    tick();
                end while (inAck);
                // next request moves through the pipeline behind the held result
                sendRequest(32'h1357_9bdf, 5'd6, shiftPkg::SHIFT_ROR);
            end
            begin
                do begin
                    tick();
                end while (!outReq);
                seen = outData;
                repeat (8) begin
                    tick();
                    checkBit("handshake outReq held", 1'b1, outReq);
                    checkData("handshake outData stable", seen, outData);
                end
                outAck = 1'b1;
                do begin
                    tick();
                end while (outReq);
                outAck = 1'b0;
                receiveResult("handshake second result", 0);
            end
        join
        checkData("handshake result", refShift(data, 5'd9, shiftPkg::SHIFT_SRA), seen);
    endtask

    task automatic testBackPressure();
        shiftPkg::shiftData dataList[4];
        dataList      = '{32'h8000_0001, 32'h7fff_fffe, 32'hdead_beef, 32'h0123_4567};
        acceptedCount = 0;
        fork
            begin
                sendRequest(dataList[0], 5'd3, shiftPkg::SHIFT_ROL);
                sendRequest(dataList[1], 5'd7, shiftPkg::SHIFT_SRA);
                sendRequest(dataList[2], 5'd13, shiftPkg::SHIFT_SLA);
                sendRequest(dataList[3], 5'd30, shiftPkg::SHIFT_ROR);
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    receiveResult($sformatf("backPressure result %0d", i), 15);
                end
            end
            begin
                // late in the first delay the pipeline holds three requests
                do begin
                    tick();
                end while (!outReq);
                repeat (14) tick();
                checkBit("backPressure inAck while full", 1'b0, inAck);
                if (acceptedCount != 3) begin
                    reportError($sformatf("%0d requests accepted while full, expected 3",
                                          acceptedCount));
                end
            end
        join
    endtask

    task automatic testRandom();
        shiftPkg::shiftData dataList[40];
        shiftPkg::shiftAmt  amtList[40];
        shiftPkg::shiftOp   opList[40];
        int                 delayList[40];
        for (int i = 0; i < 40; i++) begin
            dataList[i]  = $random(seed);
            amtList[i]   = shiftPkg::shiftAmt'($random(seed));
            opList[i]    = shiftPkg::shiftOp'($unsigned($random(seed)) % 6);
            delayList[i] = $unsigned($random(seed)) % 6;
        end
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    sendRequest(dataList[i], amtList[i], opList[i]);
                end
            end
            begin
                for (int j = 0; j < 40; j++) begin
                    receiveResult($sformatf("random %0d %s", j, opList[j].name()),
                                  delayList[j]);
                end
            end
        join
    endtask

    initial begin
        inReq         = 1'b0;
        inData        = '0;
        inAmt         = '0;
        inOp          = shiftPkg::SHIFT_SLL;
        outAck        = 1'b0;
        errorCount    = 0;
        checkCount    = 0;
        acceptedCount = 0;
        seed          = 32'h564a56dc;

        @(negedge rst); // lands at the drive offset after an edge
        tick();

        testReset();
        testEachOp();
        testHandshake();
        testBackPressure();
        testRandom();

        if (expQ.size() != 0) begin
            reportError($sformatf("%0d results never arrived", expQ.size()));
        end
        repeat (2) tick();

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog budget scales with the number of requests
    initial begin
        repeat (RequestCount * CyclesPerRequest) @(posedge clk);
        $display("ERROR: timeout, a handshake never completed within %0d cycles",
                 RequestCount * CyclesPerRequest);
        $display("checks %0d, errors %0d", checkCount, errorCount + 1);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
